// ==== Bender.yml ====
package:
  name: a2_card_glue

sources:
  - a2_glue_pkg.sv
  - reset_sync.sv
  - clock_edge_sync.sv
  - card_bus_merge.sv
  - audio_mixer.sv
  - scanline_dimmer.sv
  - heartbeat_led.sv
  - a2_card_glue.sv
  - target: simulation
    files:
      - tb_a2_card_glue.sv

// ==== a2_card_glue.sv ====
//****************************************
// Card glue top level with switch decode
// and all glue instances
//****************************************

module a2_card_glue #(
    parameter int BLINK_HALF_PERIOD   = 27_000_000,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit SCANLINES_ENABLE    = 1'b0,
    parameter bit SPEAKER_ENABLE      = 1'b0
) (
    input  logic                    clk,
    input  logic                    ext_reset,
    input  logic                    phi1_i,
    input  logic                    q3_i,
    input  logic                    a7m_i,
    input  a2_glue_pkg::bus_byte_t  ssc_data_i,
    input  logic                    ssc_rd_i,
    input  logic                    ssc_irq_n_i,
    input  a2_glue_pkg::bus_byte_t  ssp_data_i,
    input  logic                    ssp_rd_i,
    input  logic                    ssp_irq_n_i,
    input  a2_glue_pkg::bus_byte_t  mb_data_i,
    input  logic                    mb_rd_i,
    input  logic                    mb_irq_n_i,
    input  a2_glue_pkg::sample_t    ssp_audio_i,
    input  a2_glue_pkg::mb_sample_t mb_audio_l_i,
    input  a2_glue_pkg::mb_sample_t mb_audio_r_i,
    input  logic                    speaker_i,
    input  a2_glue_pkg::channel_t   pixel_r_i,
    input  a2_glue_pkg::channel_t   pixel_g_i,
    input  a2_glue_pkg::channel_t   pixel_b_i,
    input  logic                    row_lsb_i,
    input  logic [3:0]              dip_switches_n_i,
    output logic                    phi0_o,
    output logic                    phi1_posedge_o,
    output logic                    phi1_negedge_o,
    output logic                    q3_negedge_o,
    output logic                    tick_14m_o,
    output a2_glue_pkg::bus_byte_t  bus_data_o,
    output logic                    bus_d_dir_o,
    output logic                    irq_n_o,
    output a2_glue_pkg::sample_t    audio_l_o,
    output a2_glue_pkg::sample_t    audio_r_o,
    output a2_glue_pkg::channel_t   video_r_o,
    output a2_glue_pkg::channel_t   video_g_o,
    output a2_glue_pkg::channel_t   video_b_o,
    output logic [1:0]              led_o
);

    import a2_glue_pkg::*;

    logic   rst_n;
    logic   scanlines_en;
    logic   speaker_en;
    logic   a7m_posedge;
    logic   a7m_negedge;
    logic   blink;
    pixel_t pixel_in;
    pixel_t pixel_out;

    // Switches are active low; bits 2 and 3 are not used by this glue
    assign scanlines_en = SCANLINES_ENABLE | ~dip_switches_n_i[0];
    assign speaker_en   = SPEAKER_ENABLE | ~dip_switches_n_i[1];

    reset_sync u_reset_sync (
        .clk       (clk),
        .ext_reset (ext_reset),
        .rst_n_o   (rst_n)
    );

    // phi0 is the complement of phi1
    clock_edge_sync u_sync_phi1 (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .async_i   (phi1_i),
        .level_o   (),
        .level_n_o (phi0_o),
        .posedge_o (phi1_posedge_o),
        .negedge_o (phi1_negedge_o)
    );

    clock_edge_sync u_sync_q3 (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .async_i   (q3_i),
        .level_o   (),
        .level_n_o (),
        .posedge_o (),
        .negedge_o (q3_negedge_o)
    );

    clock_edge_sync u_sync_7m (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .async_i   (a7m_i),
        .level_o   (),
        .level_n_o (),
        .posedge_o (a7m_posedge),
        .negedge_o (a7m_negedge)
    );

    // Both 7M edges give the 14M tick
    assign tick_14m_o = a7m_posedge | a7m_negedge;

    card_bus_merge #(
        .BUS_DATA_OUT_ENABLE (BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE      (IRQ_OUT_ENABLE)
    ) u_card_bus_merge (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .ssc_data_i  (ssc_data_i),
        .ssc_rd_i    (ssc_rd_i),
        .ssc_irq_n_i (ssc_irq_n_i),
        .ssp_data_i  (ssp_data_i),
        .ssp_rd_i    (ssp_rd_i),
        .ssp_irq_n_i (ssp_irq_n_i),
        .mb_data_i   (mb_data_i),
        .mb_rd_i     (mb_rd_i),
        .mb_irq_n_i  (mb_irq_n_i),
        .bus_data_o  (bus_data_o),
        .bus_d_dir_o (bus_d_dir_o),
        .irq_n_o     (irq_n_o)
    );

    audio_mixer u_audio_mixer (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .speaker_i    (speaker_i),
        .speaker_en_i (speaker_en),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o)
    );

    assign pixel_in = '{r: pixel_r_i, g: pixel_g_i, b: pixel_b_i};

    scanline_dimmer u_scanline_dimmer (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .pixel_i   (pixel_in),
        .row_lsb_i (row_lsb_i),
        .dim_en_i  (scanlines_en),
        .pixel_o   (pixel_out)
    );

    assign video_r_o = pixel_out.r;
    assign video_g_o = pixel_out.g;
    assign video_b_o = pixel_out.b;

    heartbeat_led #(
        .BLINK_HALF_PERIOD (BLINK_HALF_PERIOD)
    ) u_heartbeat_led (
        .clk     (clk),
        .rst_n_i (rst_n),
        .blink_o (blink)
    );

    // LED 1 lights once the logic is out of reset
    assign led_o[0] = ~blink;
    assign led_o[1] = rst_n;

endmodule

// ==== a2_glue_pkg.sv ====
//****************************************
// Shared bus, audio and pixel types, plus
// the audio alignment and sync constants
//****************************************

package a2_glue_pkg;

    // One byte on the Apple data bus
    typedef logic [7:0] bus_byte_t;

    // Unsigned audio sample at the output width
    typedef logic [15:0] sample_t;

    // Raw sample from the sound card
    typedef logic [9:0] mb_sample_t;

    // One colour channel
    typedef logic [7:0] channel_t;

    // Full RGB pixel, red in the top byte
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } pixel_t;

    // Aligns a 10-bit sound-card sample near the top of a sample_t
    localparam int MB_SHIFT = 5;

    // Bit position that the one-bit speaker drives
    localparam int SPEAKER_SHIFT = 13;

    // Flops in each bus timing synchronizer
    localparam int SYNC_STAGES = 2;

endpackage

// ==== audio_mixer.sv ====
//****************************************
// Weighted sum of card and speaker audio
//****************************************

module audio_mixer (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  a2_glue_pkg::sample_t    ssp_audio_i,
    input  a2_glue_pkg::mb_sample_t mb_audio_l_i,
    input  a2_glue_pkg::mb_sample_t mb_audio_r_i,
    input  logic                    speaker_i,
    input  logic                    speaker_en_i,
    output a2_glue_pkg::sample_t    audio_l_o,
    output a2_glue_pkg::sample_t    audio_r_o
);

    import a2_glue_pkg::*;

    sample_t mb_l_term;
    sample_t mb_r_term;
    sample_t spk_term;
    sample_t audio_l_q;
    sample_t audio_r_q;

    // Scale each source into the 16-bit output range
    always_comb begin
        mb_l_term = sample_t'(mb_audio_l_i) << MB_SHIFT;
        mb_r_term = sample_t'(mb_audio_r_i) << MB_SHIFT;
        spk_term  = sample_t'(speaker_i && speaker_en_i) << SPEAKER_SHIFT;
    end

    // Sprite audio is mono and feeds both channels; sums wrap at 16 bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_l_q <= '0;
            audio_r_q <= '0;
        end else begin
            audio_l_q <= ssp_audio_i + mb_l_term + spk_term;
            audio_r_q <= ssp_audio_i + mb_r_term + spk_term;
        end
    end

    assign audio_l_o = audio_l_q;
    assign audio_r_o = audio_r_q;

endmodule

// ==== card_bus_merge.sv ====
//****************************************
// Card data priority select, bus direction
// and interrupt combine
//****************************************

module card_bus_merge #(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  a2_glue_pkg::bus_byte_t ssc_data_i,
    input  logic                  ssc_rd_i,
    input  logic                  ssc_irq_n_i,
    input  a2_glue_pkg::bus_byte_t ssp_data_i,
    input  logic                  ssp_rd_i,
    input  logic                  ssp_irq_n_i,
    input  a2_glue_pkg::bus_byte_t mb_data_i,
    input  logic                  mb_rd_i,
    input  logic                  mb_irq_n_i,
    output a2_glue_pkg::bus_byte_t bus_data_o,
    output logic                  bus_d_dir_o,
    output logic                  irq_n_o
);

    import a2_glue_pkg::*;

    bus_byte_t data_sel;
    bus_byte_t data_q;
    logic      any_rd;
    logic      dir_q;
    logic      irq_n_q;

    // Serial card wins, then sprite, then sound card
    always_comb begin
        if (ssc_rd_i) begin
            data_sel = ssc_data_i;
        end else if (ssp_rd_i) begin
            data_sel = ssp_data_i;
        end else if (mb_rd_i) begin
            data_sel = mb_data_i;
        end else begin
            data_sel = '0;
        end
    end

    assign any_rd = ssc_rd_i || ssp_rd_i || mb_rd_i;

    always_ff @(posedge clk) begin
        data_q <= data_sel;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q   <= 1'b0;
            irq_n_q <= 1'b1;
        end else begin
            dir_q <= any_rd && BUS_DATA_OUT_ENABLE;
            // Interrupt lines are active low, so any card pulls the output low
            if (IRQ_OUT_ENABLE) begin
                irq_n_q <= ssc_irq_n_i && ssp_irq_n_i && mb_irq_n_i;
            end else begin
                irq_n_q <= 1'b1;
            end
        end
    end

    assign bus_data_o  = data_q;
    assign bus_d_dir_o = dir_q;
    assign irq_n_o     = irq_n_q;

    a_no_drive_when_disabled : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !BUS_DATA_OUT_ENABLE |-> !bus_d_dir_o
    );

endmodule

// ==== clock_edge_sync.sv ====
//****************************************
// Bus timing synchronizer with glitch
// filter and edge pulses
//****************************************

module clock_edge_sync (
    input  logic clk,
    input  logic rst_n_i,
    input  logic async_i,
    output logic level_o,
    output logic level_n_o,
    output logic posedge_o,
    output logic negedge_o
);

    import a2_glue_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   level_q;
    logic                   posedge_q;
    logic                   negedge_q;
    logic                   sample;
    logic                   settled;

    // New samples enter at bit 0 and age toward the top bit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], async_i};
        end
    end

    // Two newest synchronized samples must agree before the level moves
    assign sample  = sync_q[SYNC_STAGES-2];
    assign settled = (sync_q[SYNC_STAGES-1] == sync_q[SYNC_STAGES-2]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            level_q   <= 1'b0;
            posedge_q <= 1'b0;
            negedge_q <= 1'b0;
        end else begin
            if (settled && (sample != level_q)) begin
                level_q <= sample;
            end
            // Pulses line up with the first cycle of the new level
            posedge_q <= settled && sample && !level_q;
            negedge_q <= settled && !sample && level_q;
        end
    end

    assign level_o   = level_q;
    assign level_n_o = ~level_q;
    assign posedge_o = posedge_q;
    assign negedge_o = negedge_q;

    a_edges_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(posedge_o && negedge_o)
    );

endmodule

// ==== filelist.f ====
a2_glue_pkg.sv
reset_sync.sv
clock_edge_sync.sv
card_bus_merge.sv
audio_mixer.sv
scanline_dimmer.sv
heartbeat_led.sv
a2_card_glue.sv
tb_a2_card_glue.sv

// ==== heartbeat_led.sv ====
//****************************************
// Status LED blink counter
//****************************************

module heartbeat_led #(
    parameter int BLINK_HALF_PERIOD = 27_000_000
) (
    input  logic clk,
    input  logic rst_n_i,
    output logic blink_o
);

    localparam int CNT_W = (BLINK_HALF_PERIOD > 1) ? $clog2(BLINK_HALF_PERIOD) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             blink_q;

    // Starts high so the inverted LED is dark during reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q   <= '0;
            blink_q <= 1'b1;
        end else if (cnt_q == CNT_W'(BLINK_HALF_PERIOD - 1)) begin
            cnt_q   <= '0;
            blink_q <= ~blink_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign blink_o = blink_q;

endmodule

// ==== reset_sync.sv ====
//****************************************
// Reset release stretcher
//****************************************

module reset_sync (
    input  logic clk,
    input  logic ext_reset,
    output logic rst_n_o
);

    logic [3:0] release_cnt_q;

    // Count up to all ones after the external release, then hold
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            release_cnt_q <= 4'd0;
        end else if (!rst_n_o) begin
            release_cnt_q <= release_cnt_q + 4'd1;
        end
    end

    // All ones is the released state
    assign rst_n_o = &release_cnt_q;

    // Once released, the internal reset stays released until ext_reset drops
    a_no_early_reassert : assert property (
        @(posedge clk) disable iff (!ext_reset)
        rst_n_o |=> rst_n_o
    );

endmodule

// ==== scanline_dimmer.sv ====
//****************************************
// Pixel stage that darkens odd rows
//****************************************

module scanline_dimmer (
    input  logic                clk,
    input  logic                rst_n_i,
    input  a2_glue_pkg::pixel_t pixel_i,
    input  logic                row_lsb_i,
    input  logic                dim_en_i,
    output a2_glue_pkg::pixel_t pixel_o
);

    import a2_glue_pkg::*;

    pixel_t pixel_q;
    logic   dim_row;

    // Odd rows only, for the CRT scanline look
    assign dim_row = dim_en_i && row_lsb_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pixel_q <= '0;
        end else if (dim_row) begin
            pixel_q.r <= pixel_i.r >> 1;
            pixel_q.g <= pixel_i.g >> 1;
            pixel_q.b <= pixel_i.b >> 1;
        end else begin
            pixel_q <= pixel_i;
        end
    end

    assign pixel_o = pixel_q;

endmodule

// ==== tb_a2_card_glue.sv ====
//****************************************
// Table-driven testbench for the card glue
//****************************************

module tb_a2_card_glue;

    import a2_glue_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int BUS_N       = 16;
    localparam int AUDIO_N     = 12;
    localparam int SCAN_N      = 12;
    localparam int EDGE_N      = 12;
    localparam int WATCHDOG_CYCLES = (BUS_N + AUDIO_N + SCAN_N + EDGE_N) * 40 + 200;

    typedef struct packed {
        logic [2:0] rd;
        bus_byte_t  ssc;
        bus_byte_t  ssp;
        bus_byte_t  mb;
        logic [2:0] irq_n;
        bus_byte_t  exp_data;
        logic       exp_dir;
        logic       exp_irq_n;
    } bus_case_t;

    typedef struct packed {
        sample_t    ssp;
        mb_sample_t l;
        mb_sample_t r;
        logic       spk;
        logic       sw_on;
        sample_t    exp_l;
        sample_t    exp_r;
    } audio_case_t;

    typedef struct packed {
        pixel_t pix;
        logic   row;
        logic   sw_on;
        pixel_t exp;
    } scan_case_t;

    typedef struct packed {
        logic [3:0] hold;
        logic       glitch;
    } edge_case_t;

    logic clk, ext_reset, phi1_i, q3_i, a7m_i;
    bus_byte_t ssc_data_i, ssp_data_i, mb_data_i, bus_data_o;
    logic ssc_rd_i, ssc_irq_n_i, ssp_rd_i, ssp_irq_n_i, mb_rd_i, mb_irq_n_i;
    sample_t ssp_audio_i, audio_l_o, audio_r_o;
    mb_sample_t mb_audio_l_i, mb_audio_r_i;
    logic speaker_i, row_lsb_i;
    channel_t pixel_r_i, pixel_g_i, pixel_b_i, video_r_o, video_g_o, video_b_o;
    logic [3:0] dip_switches_n_i;
    logic phi0_o, phi1_posedge_o, phi1_negedge_o, q3_negedge_o, tick_14m_o;
    logic bus_d_dir_o, irq_n_o;
    logic [1:0] led_o;

    bus_case_t   bus_tab[BUS_N];
    audio_case_t audio_tab[AUDIO_N];
    scan_case_t  scan_tab[SCAN_N];
    edge_case_t  edge_tab[EDGE_N];
    logic [31:0] lfsr_q = 32'hb634_bddb;
    logic [4:0]  phi1_hist = '0;
    logic        edge_chk_on = 1'b0;
    int          pos_cnt = 0;
    int          neg_cnt = 0;
    int          q3_neg_cnt = 0;
    int          tick_cnt = 0;
    int          rise_cnt = 0;
    int          fall_cnt = 0;
    int          q3_fall_cnt = 0;

    a2_card_glue #(.BLINK_HALF_PERIOD(8)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_now();
        $display("STATUS: FAIL");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_byte(input string name, input bus_byte_t got, input bus_byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    // Expected values follow the priority, sum and dimming rules
    task automatic build_tables();
        int sum;
        for (int i = 0; i < BUS_N; i++) begin
            bus_tab[i].rd    = 3'(i);
            bus_tab[i].ssc   = bus_byte_t'(take_bits(8));
            bus_tab[i].ssp   = bus_byte_t'(take_bits(8));
            bus_tab[i].mb    = bus_byte_t'(take_bits(8));
            bus_tab[i].irq_n = 3'(take_bits(3));
            bus_tab[i].exp_data = bus_tab[i].rd[2] ? bus_tab[i].ssc :
                                  bus_tab[i].rd[1] ? bus_tab[i].ssp :
                                  bus_tab[i].rd[0] ? bus_tab[i].mb  : 8'h00;
            bus_tab[i].exp_dir   = |bus_tab[i].rd;
            bus_tab[i].exp_irq_n = &bus_tab[i].irq_n;
        end
        for (int i = 0; i < AUDIO_N; i++) begin
            audio_tab[i].ssp   = sample_t'(take_bits(16));
            audio_tab[i].l     = mb_sample_t'(take_bits(10));
            audio_tab[i].r     = mb_sample_t'(take_bits(10));
            audio_tab[i].spk   = take_bits(1) != 0;
            audio_tab[i].sw_on = i[0];
            if (i == 0) begin
                // Largest inputs on every source, the sum wraps
                audio_tab[i] = '{16'hffff, 10'h3ff, 10'h3ff, 1'b1, 1'b1, 16'h0, 16'h0};
            end
            sum = audio_tab[i].ssp + audio_tab[i].l * (1 << MB_SHIFT);
            if (audio_tab[i].spk && audio_tab[i].sw_on) begin
                sum = sum + (1 << SPEAKER_SHIFT);
            end
            audio_tab[i].exp_l = sample_t'(sum % 65536);
            sum = audio_tab[i].ssp + audio_tab[i].r * (1 << MB_SHIFT);
            if (audio_tab[i].spk && audio_tab[i].sw_on) begin
                sum = sum + (1 << SPEAKER_SHIFT);
            end
            audio_tab[i].exp_r = sample_t'(sum % 65536);
        end
        for (int i = 0; i < SCAN_N; i++) begin
            scan_tab[i].pix   = pixel_t'(take_bits(24));
            scan_tab[i].row   = i[0];
            scan_tab[i].sw_on = i[1];
            scan_tab[i].exp   = scan_tab[i].pix;
            if (scan_tab[i].row && scan_tab[i].sw_on) begin
                scan_tab[i].exp.r = scan_tab[i].pix.r / 2;
                scan_tab[i].exp.g = scan_tab[i].pix.g / 2;
                scan_tab[i].exp.b = scan_tab[i].pix.b / 2;
            end
        end
        for (int i = 0; i < EDGE_N; i++) begin
            edge_tab[i].hold   = 4'(3 + take_bits(3));
            edge_tab[i].glitch = (i == 0) || (take_bits(1) != 0);
        end
    endtask

    // Input history at the negedges, newest in bit 0
    always @(negedge clk) begin
        phi1_hist = {phi1_hist[3:0], phi1_i};
        if (edge_chk_on) begin
            if (phi1_hist[3] != phi1_hist[4]) begin
                check_bit("phi0_o", phi0_o, ~phi1_hist[3]);
            end
            if (phi1_posedge_o) begin
                pos_cnt++;
            end
            if (phi1_negedge_o) begin
                neg_cnt++;
            end
            if (q3_negedge_o) begin
                q3_neg_cnt++;
            end
            if (tick_14m_o) begin
                tick_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        fail_now();
    end

    initial begin
        int last;
        int changes;
        logic prev;
        ext_reset = 1'b0;
        {phi1_i, q3_i, a7m_i, speaker_i, row_lsb_i} = '0;
        {ssc_data_i, ssp_data_i, mb_data_i} = '0;
        {ssc_rd_i, ssp_rd_i, mb_rd_i} = '0;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        {ssp_audio_i, mb_audio_l_i, mb_audio_r_i} = '0;
        {pixel_r_i, pixel_g_i, pixel_b_i} = '0;
        dip_switches_n_i = 4'hf;
        build_tables();

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("bus_d_dir_o", bus_d_dir_o, 1'b0);
        check_bit("irq_n_o", irq_n_o, 1'b1);
        check_sample("audio_l_o", audio_l_o, '0);
        check_sample("audio_r_o", audio_r_o, '0);
        check_pixel("video", {video_r_o, video_g_o, video_b_o}, '0);
        check_bit("led_o[0]", led_o[0], 1'b0);
        check_bit("led_o[1]", led_o[1], 1'b0);
        @(posedge clk);
        #DRIVE_DELAY ext_reset = 1'b1;
        for (int k = 1; k <= 15; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("led_o[1]", led_o[1], k == 15);
        end

        // Heartbeat spacing
        last = -1;
        changes = 0;
        prev = led_o[0];
        for (int cyc = 1; changes < 4; cyc++) begin
            @(negedge clk);
            if (cyc > 40) begin
                $display("led_o[0] stopped toggling");
                fail_now();
            end
            if (led_o[0] != prev) begin
                if (last >= 0) begin
                    check_count("led_o[0] interval", cyc - last, 8);
                end
                last = cyc;
                changes++;
                prev = led_o[0];
            end
        end

        for (int i = 0; i < BUS_N; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            {ssc_rd_i, ssp_rd_i, mb_rd_i} = bus_tab[i].rd;
            {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = bus_tab[i].irq_n;
            ssc_data_i = bus_tab[i].ssc;
            ssp_data_i = bus_tab[i].ssp;
            mb_data_i  = bus_tab[i].mb;
            @(posedge clk);
            @(negedge clk);
            check_byte("bus_data_o", bus_data_o, bus_tab[i].exp_data);
            check_bit("bus_d_dir_o", bus_d_dir_o, bus_tab[i].exp_dir);
            check_bit("irq_n_o", irq_n_o, bus_tab[i].exp_irq_n);
        end

        for (int i = 0; i < AUDIO_N; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            ssp_audio_i  = audio_tab[i].ssp;
            mb_audio_l_i = audio_tab[i].l;
            mb_audio_r_i = audio_tab[i].r;
            speaker_i    = audio_tab[i].spk;
            dip_switches_n_i = {2'b11, ~audio_tab[i].sw_on, 1'b1};
            @(posedge clk);
            @(negedge clk);
            check_sample("audio_l_o", audio_l_o, audio_tab[i].exp_l);
            check_sample("audio_r_o", audio_r_o, audio_tab[i].exp_r);
        end

        for (int i = 0; i < SCAN_N; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            {pixel_r_i, pixel_g_i, pixel_b_i} = scan_tab[i].pix;
            row_lsb_i = scan_tab[i].row;
            dip_switches_n_i = {3'b111, ~scan_tab[i].sw_on};
            @(posedge clk);
            @(negedge clk);
            check_pixel("video", {video_r_o, video_g_o, video_b_o}, scan_tab[i].exp);
        end

        // phi1 toggles with random holds while 7M only sees one-cycle glitches
        edge_chk_on = 1'b1;
        for (int i = 0; i < EDGE_N; i++) begin
            for (int c = 0; c < edge_tab[i].hold; c++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                if (c == 0) begin
                    phi1_i = ~phi1_i;
                    if (phi1_i) begin
                        rise_cnt++;
                    end else begin
                        fall_cnt++;
                    end
                end
                // Q3 moves on odd segments only, so its edge count differs from phi1
                if (c == 1 && i[0]) begin
                    q3_i = ~q3_i;
                    if (!q3_i) begin
                        q3_fall_cnt++;
                    end
                end
                if (edge_tab[i].glitch) begin
                    a7m_i = (c == 1);
                end
            end
        end
        repeat (6) @(posedge clk);
        check_count("phi1_posedge_o pulses", pos_cnt, rise_cnt);
        check_count("phi1_negedge_o pulses", neg_cnt, fall_cnt);
        check_count("q3_negedge_o pulses", q3_neg_cnt, q3_fall_cnt);
        check_count("tick_14m_o pulses", tick_cnt, 0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
